// File: Makefile
TOP = tb_spi_reg

# rebuilt only when a source or the file list changes
obj_dir/V$(TOP): compile.f $(wildcard include/*.svh verilog/*.sv tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log

# failing status when the log shows the fail message or lacks the pass message
check: run
	@if grep -q "Verification failed" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run check clean

// File: compile.f
+incdir+include
verilog/spi_reg_pkg.sv
verilog/wb_if.sv
verilog/crc8_calc.sv
verilog/spi_shift_frontend.sv
verilog/spi_frame_ctrl.sv
verilog/reg_bank.sv
verilog/spi_reg_top.sv
tb/tb_spi_reg.sv

// File: include/spi_reg_config.svh
//========================================
// widths, frame length and access gap of
// the SPI register port, shared by the
// RTL and the testbench through `include
//========================================
`ifndef SPI_REG_CONFIG_SVH
`define SPI_REG_CONFIG_SVH

// register bank geometry
`define REG_AW 7
`define REG_DW 8

// one frame is command, data and CRC bytes
`define FRAME_BITS 24

// chip-select high time needed before a frame, in system clocks
`define MIN_ACC_GAP 64
`define GAP_CNT_W 8

`endif

// File: tb/tb_spi_reg.sv
//========================================
// testbench for the SPI register port:
// random frames from an LCG, a register
// and response model, miso and error checks
//========================================
`timescale 1ns/1ps
`include "spi_reg_config.svh"

module tb_spi_reg;

    localparam int N_RANDOM    = 200;
    localparam int N_FRAMES    = 300;
    localparam int LONG_GAP    = `MIN_ACC_GAP + 40;
    localparam int FRAME_CLKS  = 8 + 25 * 8;
    localparam int CYCLE_LIMIT = 100 + N_FRAMES * (FRAME_CLKS + LONG_GAP + 40) * 2;

    logic        clk;
    logic        rst_n;
    logic        spi_en;
    logic        spi_sclk;
    logic        spi_csb;
    logic        spi_mosi;
    logic        spi_miso;
    logic        spi_err;
    logic [31:0] lcg_state;
    logic [7:0]  model_regs [128];
    logic [23:0] exp_resp;
    logic [23:0] shadow;
    int          idle_sum;
    int          frame_no;
    int          errors;
    int          checks;
    int          cycles = 0;

    spi_reg_top dut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_spi_en   (spi_en),
        .i_spi_sclk (spi_sclk),
        .i_spi_csb  (spi_csb),
        .i_spi_mosi (spi_mosi),
        .o_spi_miso (spi_miso),
        .o_spi_err  (spi_err)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d clocks, the frames did not finish", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    //========================================
    // random numbers and reference CRC
    //========================================
    function automatic int rand_below(input int n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[31:8]) % n;
    endfunction

    // byte-wise CRC-8, poly 0x07, zero init
    function automatic logic [7:0] crc8_ref(input logic [15:0] msg);
        logic [7:0] crc;
        crc = 8'h00;
        for (int b = 1; b >= 0; b--) begin
            crc = crc ^ msg[b*8 +: 8];
            for (int k = 0; k < 8; k++) begin
                if (crc[7]) begin
                    crc = {crc[6:0], 1'b0} ^ 8'h07;
                end else begin
                    crc = {crc[6:0], 1'b0};
                end
            end
        end
        return crc;
    endfunction

    function automatic logic [23:0] make_frame(input logic op, input logic [6:0] adr,
                                               input logic [7:0] data);
        return {op, adr, data, crc8_ref({op, adr, data})};
    endfunction

    function automatic int long_gap();
        return LONG_GAP + rand_below(40);
    endfunction

    //========================================
    // SPI host, model update and checks
    //========================================
    // sends the low nbits of bits MSB first, then holds csb high for post_gap clocks
    task automatic send_frame(input logic [31:0] bits, input int nbits, input int post_gap);
        logic [23:0] got;
        logic [23:0] mask;
        logic [7:0]  cmd;
        logic [7:0]  data;
        logic        accept;
        int          idx;
        int          err_pulses;
        got  = '0;
        mask = '0;
        spi_csb = 1'b0;
        repeat (4) @(negedge clk);
        for (int k = nbits - 1; k >= 0; k--) begin
            spi_mosi = bits[k];
            shadow   = {shadow[22:0], bits[k]};
            repeat (4) @(negedge clk);
            idx = nbits - 1 - k;
            // miso is sampled as sclk rises
            if (idx < 24) begin
                got[23-idx]  = spi_miso;
                mask[23-idx] = 1'b1;
            end
            spi_sclk = 1'b1;
            repeat (4) @(negedge clk);
            spi_sclk = 1'b0;
        end
        repeat (4) @(negedge clk);
        spi_csb = 1'b1;

        checks++;
        if ((got & mask) !== (exp_resp & mask)) begin
            errors++;
            $display("Fail o_spi_miso frame %0d: got %h exp %h", frame_no,
                     got & mask, exp_resp & mask);
        end

        // judge the last 24 bits shifted
        cmd    = shadow[23:16];
        data   = shadow[15:8];
        accept = spi_en && (crc8_ref(shadow[23:8]) == shadow[7:0])
                 && (idle_sum >= `MIN_ACC_GAP);
        if (accept) begin
            if (cmd[7]) begin
                model_regs[cmd[6:0]] = data;
            end else begin
                data = model_regs[cmd[6:0]];
            end
            exp_resp = {cmd, data, crc8_ref({cmd, data})};
            idle_sum = 0;
        end

        err_pulses = 0;
        for (int c = 0; c < post_gap; c++) begin
            @(negedge clk);
            if (spi_err && (c < 10)) begin
                err_pulses++;
            end else if (spi_err) begin
                errors++;
                $display("o_spi_err pulsed %0d clocks after chip-select rose in frame %0d",
                         c, frame_no);
            end
        end
        checks++;
        if (err_pulses != ((spi_en && !accept) ? 1 : 0)) begin
            errors++;
            $display("Fail o_spi_err pulses frame %0d: got %h exp %h", frame_no,
                     err_pulses, (spi_en && !accept) ? 1 : 0);
        end
        idle_sum += post_gap;
        frame_no++;
    endtask

    task automatic random_access(input int post_gap);
        send_frame(32'(make_frame(1'(rand_below(2)), 7'(rand_below(128)),
                                  8'(rand_below(256)))), 24, post_gap);
    endtask

    //========================================
    // test sequence
    //========================================
    initial begin
        logic [6:0]  adr;
        logic [23:0] frame;
        clk       = 1'b0;
        rst_n     = 1'b0;
        spi_en    = 1'b1;
        spi_sclk  = 1'b0;
        spi_csb   = 1'b1;
        spi_mosi  = 1'b0;
        lcg_state = 32'ha1a2ae7a;
        exp_resp  = '0;
        shadow    = '0;
        idle_sum  = 1000;
        frame_no  = 0;
        errors    = 0;
        checks    = 0;
        for (int i = 0; i < 128; i++) begin
            model_regs[i] = 8'h00;
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);

        // response after reset is zero, then random traffic
        for (int i = 0; i < N_RANDOM + 1; i++) begin
            random_access(long_gap());
        end

        // corrupted data or CRC bit, then read back
        for (int i = 0; i < 10; i++) begin
            adr   = 7'(rand_below(128));
            frame = make_frame(1'b1, adr, 8'(rand_below(256))) ^ (24'h1 << rand_below(16));
            send_frame(32'(frame), 24, long_gap());
            send_frame(32'(make_frame(1'b0, adr, 8'h00)), 24, long_gap());
        end

        // write after a short gap is refused
        for (int i = 0; i < 10; i++) begin
            adr = 7'(rand_below(128));
            random_access(`MIN_ACC_GAP - 44 + rand_below(15));
            send_frame(32'(make_frame(1'b1, adr, 8'(rand_below(256)))), 24, long_gap());
            send_frame(32'(make_frame(1'b0, adr, 8'h00)), 24, long_gap());
        end

        // port disabled
        for (int i = 0; i < 5; i++) begin
            adr    = 7'(rand_below(128));
            spi_en = 1'b0;
            send_frame(32'(make_frame(1'b1, adr, 8'(rand_below(256)))), 24, long_gap());
            spi_en = 1'b1;
            send_frame(32'(make_frame(1'b0, adr, 8'h00)), 24, long_gap());
        end

        // 25 and 23 bit frames
        for (int i = 0; i < 10; i++) begin
            frame = make_frame(1'(rand_below(2)), 7'(rand_below(128)), 8'(rand_below(256)));
            send_frame({7'd0, 1'(rand_below(2)), frame}, 25, long_gap());
            frame = make_frame(1'(rand_below(2)), 7'(rand_below(128)), 8'(rand_below(256)));
            send_frame(32'(frame), 23, long_gap());
        end
        random_access(long_gap());

        $display("errors %0d, checks %0d", errors, checks);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verilog/crc8_calc.sv
//========================================
// CRC-8 over a 16-bit message, poly 0x07
// with zero init, MSB first; purely
// combinational, unrolled into xor logic
//========================================
`timescale 1ns/1ps

module crc8_calc (
    input  logic [15:0] i_msg,
    output logic [7:0]  o_crc
);

    localparam logic [7:0] POLY = 8'h07;

    logic [7:0] crc_acc;
    logic       fb;

    //========================================
    // bit-serial form, flattened by the loop
    //========================================
    always_comb begin
        crc_acc = 8'h00;
        fb      = 1'b0;
        for (int i = 15; i >= 0; i--) begin
            // feedback is the top bit against the next message bit
            fb      = crc_acc[7] ^ i_msg[i];
            crc_acc = {crc_acc[6:0], 1'b0} ^ (fb ? POLY : 8'h00);
        end
    end

    // no final xor
    assign o_crc = crc_acc;

endmodule

// File: verilog/reg_bank.sv
//========================================
// 128 x 8 register bank behind a Wishbone
// classic slave; every strobe is acked
// one clock later, no wait states
//========================================
`timescale 1ns/1ps
`include "spi_reg_config.svh"

module reg_bank (
    input  logic i_clk,
    input  logic i_rst_n,
    wb_if.slave  wb
);

    localparam int DEPTH = 1 << `REG_AW;

    logic [`REG_DW-1:0] regs [DEPTH];
    logic [`REG_DW-1:0] rdata_q;
    logic               ack_q;
    logic               req;

    // new request only while no ack is out
    assign req = wb.cyc && wb.stb && !ack_q;

    //========================================
    // storage and handshake
    //========================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
            rdata_q <= '0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= req;
            if (req) begin
                // read data returns the value before a write
                rdata_q <= regs[wb.adr];
                if (wb.we) begin
                    regs[wb.adr] <= wb.dat_w;
                end
            end
        end
    end

    assign wb.ack   = ack_q;
    assign wb.dat_r = rdata_q;

    // master must drop stb right after ack
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        wb.ack |=> !wb.stb);

endmodule

// File: verilog/spi_frame_ctrl.sv
//========================================
// frame controller: checks CRC and access
// gap, runs one Wishbone classic cycle per
// accepted frame and builds the response
//========================================
`timescale 1ns/1ps
`include "spi_reg_config.svh"

module spi_frame_ctrl (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_spi_en,
    input  logic [`FRAME_BITS-1:0] i_frame,
    input  logic                   i_frame_end,
    input  logic                   i_csb_idle,
    output logic [`FRAME_BITS-1:0] o_resp,
    output logic                   o_spi_err,
    wb_if.master                   wb
);

    spi_reg_pkg::ctrl_state_e state;
    spi_reg_pkg::spi_op_e     frame_op;
    spi_reg_pkg::spi_op_e     op_q;

    logic [`REG_DW-1:0]    frame_cmd;
    logic [`REG_DW-1:0]    frame_data;
    logic [7:0]            frame_crc;
    logic [`REG_AW-1:0]    adr_q;
    logic [`REG_DW-1:0]    dat_q;
    logic                  cyc_q;
    logic                  stb_q;
    logic [`GAP_CNT_W-1:0] gap_cnt;
    logic                  gap_ok;
    logic                  crc_ok;
    logic                  accept;
    logic [15:0]           crc_msg;
    logic [7:0]            crc_val;

    //========================================
    // frame fields and checks
    //========================================
    assign frame_cmd  = i_frame[`FRAME_BITS-1 -: `REG_DW];
    assign frame_data = i_frame[8 +: `REG_DW];
    assign frame_crc  = i_frame[7:0];
    assign frame_op   = spi_reg_pkg::spi_op_e'(frame_cmd[`REG_DW-1]);

    // one CRC unit: response bytes in RESP_LOAD, incoming frame otherwise
    assign crc_msg = (state == spi_reg_pkg::RESP_LOAD) ? {op_q, adr_q, dat_q}
                                                       : {frame_cmd, frame_data};

    crc8_calc u_crc (
        .i_msg (crc_msg),
        .o_crc (crc_val)
    );

    assign crc_ok = (crc_val == frame_crc);
    assign gap_ok = (gap_cnt >= `GAP_CNT_W'(`MIN_ACC_GAP));
    assign accept = (state == spi_reg_pkg::CHECK) && crc_ok && gap_ok;

    // idle time since the last accepted frame, saturates
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            gap_cnt <= '1;
        end else if (accept) begin
            gap_cnt <= '0;
        end else if (i_csb_idle && (gap_cnt != '1)) begin
            gap_cnt <= gap_cnt + 1'b1;
        end
    end

    //========================================
    // control FSM and bus handshake
    //========================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= spi_reg_pkg::IDLE;
            cyc_q     <= 1'b0;
            stb_q     <= 1'b0;
            o_spi_err <= 1'b0;
        end else begin
            o_spi_err <= 1'b0;
            case (state)
                spi_reg_pkg::IDLE: begin
                    // disabled port drops frames without an error
                    if (i_frame_end && i_spi_en) begin
                        state <= spi_reg_pkg::CHECK;
                    end
                end
                spi_reg_pkg::CHECK: begin
                    if (accept) begin
                        cyc_q <= 1'b1;
                        stb_q <= 1'b1;
                        state <= spi_reg_pkg::WB_CYCLE;
                    end else begin
                        o_spi_err <= 1'b1;
                        state     <= spi_reg_pkg::IDLE;
                    end
                end
                spi_reg_pkg::WB_CYCLE: begin
                    if (wb.ack) begin
                        cyc_q <= 1'b0;
                        stb_q <= 1'b0;
                        state <= spi_reg_pkg::RESP_LOAD;
                    end
                end
                default: begin
                    state <= spi_reg_pkg::IDLE;
                end
            endcase
        end
    end

    // bus payload; dat_q carries write data out and read data back
    always_ff @(posedge i_clk) begin
        if (accept) begin
            op_q  <= frame_op;
            adr_q <= frame_cmd[`REG_AW-1:0];
            dat_q <= frame_data;
        end else if ((state == spi_reg_pkg::WB_CYCLE) && wb.ack
                     && (op_q == spi_reg_pkg::OP_READ)) begin
            dat_q <= wb.dat_r;
        end
    end

    assign wb.cyc   = cyc_q;
    assign wb.stb   = stb_q;
    assign wb.we    = (op_q == spi_reg_pkg::OP_WRITE);
    assign wb.adr   = adr_q;
    assign wb.dat_w = dat_q;

    //========================================
    // response for the next frame
    //========================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_resp <= '0;
        end else if (state == spi_reg_pkg::RESP_LOAD) begin
            o_resp <= {op_q, adr_q, dat_q, crc_val};
        end
    end

    // a new frame cannot end while the previous one is still in flight
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_frame_end |-> (state == spi_reg_pkg::IDLE));

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        wb.stb |-> wb.cyc);

endmodule

// File: verilog/spi_reg_pkg.sv
//========================================
// types shared by the SPI register port:
// controller states and frame opcodes
//========================================
package spi_reg_pkg;

    //========================================
    // frame controller FSM
    //========================================
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        CHECK     = 2'd1,
        WB_CYCLE  = 2'd2,
        RESP_LOAD = 2'd3
    } ctrl_state_e;

    //========================================
    // command byte bit 7
    //========================================
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } spi_op_e;

endpackage

// File: verilog/spi_reg_top.sv
//========================================
// SPI register port top level: front end,
// frame controller and register bank
//========================================
`timescale 1ns/1ps
`include "spi_reg_config.svh"

module spi_reg_top (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_spi_en,
    input  logic i_spi_sclk,
    input  logic i_spi_csb,
    input  logic i_spi_mosi,
    output logic o_spi_miso,
    output logic o_spi_err
);

    logic [`FRAME_BITS-1:0] frame;
    logic [`FRAME_BITS-1:0] resp;
    logic                   frame_end;
    logic                   csb_idle;

    wb_if wb_bus ();

    spi_shift_frontend u_frontend (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_spi_sclk  (i_spi_sclk),
        .i_spi_csb   (i_spi_csb),
        .i_spi_mosi  (i_spi_mosi),
        .o_spi_miso  (o_spi_miso),
        .i_resp      (resp),
        .o_frame     (frame),
        .o_frame_end (frame_end),
        .o_csb_idle  (csb_idle)
    );

    spi_frame_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_spi_en    (i_spi_en),
        .i_frame     (frame),
        .i_frame_end (frame_end),
        .i_csb_idle  (csb_idle),
        .o_resp      (resp),
        .o_spi_err   (o_spi_err),
        .wb          (wb_bus.master)
    );

    reg_bank u_bank (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .wb      (wb_bus.slave)
    );

endmodule

// File: verilog/spi_shift_frontend.sv
//========================================
// SPI mode 0 front end: MOSI shifter and
// MISO serializer on sclk, chip-select
// sync and frame-end pulse on i_clk
//========================================
`timescale 1ns/1ps
`include "spi_reg_config.svh"

module spi_shift_frontend (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_spi_sclk,
    input  logic                   i_spi_csb,
    input  logic                   i_spi_mosi,
    output logic                   o_spi_miso,
    input  logic [`FRAME_BITS-1:0] i_resp,
    output logic [`FRAME_BITS-1:0] o_frame,
    output logic                   o_frame_end,
    output logic                   o_csb_idle
);

    localparam int PTR_W = $clog2(`FRAME_BITS);
    localparam logic [PTR_W-1:0] PTR_TOP = PTR_W'(`FRAME_BITS - 1);

    logic [`FRAME_BITS-1:0] rx_shift;
    logic [PTR_W-1:0]       bit_ptr;
    logic                   csb_meta;
    logic                   csb_sync;
    logic                   csb_sync_q;

    //========================================
    // sclk domain
    //========================================
    // only the last FRAME_BITS bits survive
    always_ff @(posedge i_spi_sclk) begin
        rx_shift <= {rx_shift[`FRAME_BITS-2:0], i_spi_mosi};
    end

    // pointer parks on the MSB while chip-select is high
    always_ff @(negedge i_spi_sclk or posedge i_spi_csb) begin
        if (i_spi_csb) begin
            bit_ptr <= PTR_TOP;
        end else if (bit_ptr == '0) begin
            bit_ptr <= PTR_TOP;
        end else begin
            bit_ptr <= bit_ptr - 1'b1;
        end
    end

    // first bit valid from chip-select fall, next ones after each falling sclk
    assign o_spi_miso = i_resp[bit_ptr];

    //========================================
    // system clock domain
    //========================================
    // two-flop sync, idle level is high
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            csb_meta   <= 1'b1;
            csb_sync   <= 1'b1;
            csb_sync_q <= 1'b1;
        end else begin
            csb_meta   <= i_spi_csb;
            csb_sync   <= csb_meta;
            csb_sync_q <= csb_sync;
        end
    end

    // rising edge of the synced chip-select ends a frame
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_frame_end <= 1'b0;
        end else begin
            o_frame_end <= csb_sync & ~csb_sync_q;
        end
    end

    assign o_csb_idle = csb_sync;

    // shifter is quiet from chip-select rise until the next frame
    assign o_frame = rx_shift;

endmodule

// File: verilog/wb_if.sv
//========================================
// Wishbone classic bus between the frame
// controller (master) and the register
// bank (slave)
//========================================
`timescale 1ns/1ps
`include "spi_reg_config.svh"

interface wb_if;

    logic               cyc;
    logic               stb;
    logic               we;
    logic [`REG_AW-1:0] adr;
    logic [`REG_DW-1:0] dat_w;
    logic [`REG_DW-1:0] dat_r;
    logic               ack;

    // frame controller side
    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    // register bank side
    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface
